/* include/tetris_defines.svh */
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// board size
`define GRID_ROWS 20
`define GRID_COLS 10

// index and count widths
`define ROW_W 5
`define COL_W 4
`define HGT_W 5

// each feature output
`define FEAT_W 8

`endif

/* hdl/tetris_feature_pkg.sv */
`include "tetris_defines.svh"

package tetris_feature_pkg;

    // occupancy bits, row 0 is the top row
    typedef logic [`GRID_ROWS-1:0][`GRID_COLS-1:0] grid_t;

    // one column of the height stream
    typedef struct packed {
        logic              valid;
        logic [`COL_W-1:0] col;
        logic [`HGT_W-1:0] height;
    } col_height_t;

    // one column of the hole stream
    typedef struct packed {
        logic              valid;
        logic [`COL_W-1:0] col;
        logic [`HGT_W-1:0] holes;
    } col_holes_t;

    typedef struct packed {
        logic [`FEAT_W-1:0] lines_cleared;
        logic [`FEAT_W-1:0] holes;
        logic [`FEAT_W-1:0] bumpiness;
        logic [`FEAT_W-1:0] height_sum;
    } features_t;

endpackage

/* hdl/line_clear_unit.sv */
`include "tetris_defines.svh"

module line_clear_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      extract_start,
    input  tetris_feature_pkg::grid_t tetris_grid,
    input  logic                      hold,
    output tetris_feature_pkg::grid_t cleared_grid,
    output logic [`FEAT_W-1:0]        lines_cleared,
    output logic                      clear_done
);
    import tetris_feature_pkg::*;

    localparam logic [`ROW_W-1:0] LAST_ROW = `ROW_W'(`GRID_ROWS - 1);

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        WAIT_HOLD
    } clear_state_t;

    clear_state_t       state;
    grid_t              work_grid;
    grid_t              out_grid;
    logic [`ROW_W-1:0]  rd_ptr;
    logic [`ROW_W-1:0]  wr_ptr;
    logic [`FEAT_W-1:0] line_cnt;
    logic               row_full;
    logic               start_ok;

    assign start_ok = extract_start && (state == IDLE) && !hold;
    assign row_full = &work_grid[rd_ptr];

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            line_cnt   <= '0;
            clear_done <= 1'b0;
        end else begin
            clear_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_ok) begin
                        state    <= CLEAR;
                        rd_ptr   <= LAST_ROW;
                        wr_ptr   <= LAST_ROW;
                        line_cnt <= '0;
                    end
                end
                CLEAR: begin
                    // full rows are dropped, the rest move down to wr_ptr
                    if (row_full) begin
                        line_cnt <= line_cnt + 1'b1;
                    end else begin
                        wr_ptr <= wr_ptr - 1'b1;
                    end
                    if (rd_ptr == '0) begin
                        state      <= WAIT_HOLD;
                        clear_done <= 1'b1;
                    end else begin
                        rd_ptr <= rd_ptr - 1'b1;
                    end
                end
                // scanners still read cleared_grid until the result is held
                WAIT_HOLD: begin
                    if (hold) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // row copy
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start_ok) begin
            work_grid <= tetris_grid;
        end else if (state == CLEAR) begin
            if (!row_full) begin
                out_grid[wr_ptr] <= work_grid[rd_ptr];
            end
            // last row: blank whatever is left above the write pointer
            if (rd_ptr == '0) begin
                for (int r = 0; r < `GRID_ROWS; r++) begin
                    if (r < int'(wr_ptr) || (r == int'(wr_ptr) && row_full)) begin
                        out_grid[r] <= '0;
                    end
                end
            end
        end
    end

    assign cleared_grid  = out_grid;
    assign lines_cleared = line_cnt;

    // the combiner never holds a result while a board is being cleared
    assert property (@(posedge clk) disable iff (rst) (state == CLEAR) |-> !hold);

    assert property (@(posedge clk) disable iff (rst)
        (state == CLEAR) |-> (rd_ptr <= LAST_ROW) && (wr_ptr <= LAST_ROW) && (wr_ptr >= rd_ptr));

    assert property (@(posedge clk) disable iff (rst) start_ok |=> ##`GRID_ROWS clear_done);

endmodule

/* hdl/column_height_scan.sv */
`include "tetris_defines.svh"

module column_height_scan (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            clear_done,
    input  tetris_feature_pkg::grid_t       cleared_grid,
    output tetris_feature_pkg::col_height_t height_out
);
    localparam logic [`COL_W-1:0] LAST_COL = `COL_W'(`GRID_COLS - 1);

    logic              busy;
    logic [`COL_W-1:0] col_cnt;
    logic [`COL_W-1:0] sel_col;
    logic              found;
    logic [`ROW_W-1:0] top_row;
    logic [`HGT_W-1:0] col_height;

    // column 0 goes out on the clear_done edge
    assign sel_col = busy ? col_cnt : '0;

    // search from the bottom so the topmost filled row wins
    always_comb begin
        found   = 1'b0;
        top_row = '0;
        for (int r = `GRID_ROWS - 1; r >= 0; r--) begin
            if (cleared_grid[r][sel_col]) begin
                found   = 1'b1;
                top_row = `ROW_W'(r);
            end
        end
        col_height = found ? (`HGT_W'(`GRID_ROWS) - top_row) : '0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            col_cnt    <= '0;
            height_out <= '0;
        end else if (clear_done || busy) begin
            height_out.valid  <= 1'b1;
            height_out.col    <= sel_col;
            height_out.height <= col_height;
            col_cnt           <= sel_col + 1'b1;
            busy              <= (sel_col != LAST_COL);
        end else begin
            height_out.valid <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        height_out.valid |-> (height_out.col < `GRID_COLS));

endmodule

/* hdl/column_hole_scan.sv */
`include "tetris_defines.svh"

module column_hole_scan (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           clear_done,
    input  tetris_feature_pkg::grid_t      cleared_grid,
    output tetris_feature_pkg::col_holes_t holes_out
);
    localparam logic [`COL_W-1:0] LAST_COL = `COL_W'(`GRID_COLS - 1);

    logic              busy;
    logic [`COL_W-1:0] col_cnt;
    logic [`COL_W-1:0] sel_col;
    logic              covered;
    logic [`HGT_W-1:0] hole_cnt;

    assign sel_col = busy ? col_cnt : '0;

    ////////////////////////////////////////
    // hole count, top to bottom
    ////////////////////////////////////////

    // an empty cell counts once something filled sits above it
    always_comb begin
        covered  = 1'b0;
        hole_cnt = '0;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            if (cleared_grid[r][sel_col]) begin
                covered = 1'b1;
            end else if (covered) begin
                hole_cnt = hole_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // column walk
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            col_cnt   <= '0;
            holes_out <= '0;
        end else if (clear_done || busy) begin
            holes_out.valid <= 1'b1;
            holes_out.col   <= sel_col;
            holes_out.holes <= hole_cnt;
            col_cnt         <= sel_col + 1'b1;
            busy            <= (sel_col != LAST_COL);
        end else begin
            holes_out.valid <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        holes_out.valid |-> (holes_out.col < `GRID_COLS));

endmodule

/* hdl/feature_combine.sv */
`include "tetris_defines.svh"

module feature_combine (
    input  logic                            clk,
    input  logic                            rst,
    input  tetris_feature_pkg::col_height_t height_in,
    input  tetris_feature_pkg::col_holes_t  holes_in,
    input  logic [`FEAT_W-1:0]              lines_cleared,
    input  logic                            ofm_done,
    output logic                            extract_ready,
    output tetris_feature_pkg::features_t   features
);
    import tetris_feature_pkg::*;

    localparam logic [`COL_W-1:0] LAST_COL = `COL_W'(`GRID_COLS - 1);

    features_t          feat_q;
    logic [`HGT_W-1:0]  prev_height;
    logic [`HGT_W-1:0]  step;
    logic [`FEAT_W-1:0] height_ext;
    logic [`FEAT_W-1:0] holes_ext;
    logic [`FEAT_W-1:0] step_ext;
    logic               first_col;

    assign first_col = (height_in.col == '0);

    // absolute height step from the previous column
    assign step = (height_in.height > prev_height) ? (height_in.height - prev_height)
                                                   : (prev_height - height_in.height);

    assign height_ext = `FEAT_W'(height_in.height);
    assign holes_ext  = `FEAT_W'(holes_in.holes);
    assign step_ext   = `FEAT_W'(step);

    ////////////////////////////////////////
    // accumulate
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            feat_q        <= '0;
            prev_height   <= '0;
            extract_ready <= 1'b0;
        end else if (height_in.valid) begin
            prev_height <= height_in.height;
            if (first_col) begin
                // new board starts the sums over
                feat_q.lines_cleared <= lines_cleared;
                feat_q.height_sum    <= height_ext;
                feat_q.holes         <= holes_ext;
                feat_q.bumpiness     <= '0;
            end else begin
                feat_q.height_sum <= feat_q.height_sum + height_ext;
                feat_q.holes      <= feat_q.holes + holes_ext;
                feat_q.bumpiness  <= feat_q.bumpiness + step_ext;
            end
            if (height_in.col == LAST_COL) begin
                extract_ready <= 1'b1;
            end
        end else if (extract_ready && ofm_done) begin
            extract_ready <= 1'b0;
        end
    end

    assign features = feat_q;

    // both scanners run in lock step off the same clear_done
    assert property (@(posedge clk) disable iff (rst) height_in.valid == holes_in.valid);

    assert property (@(posedge clk) disable iff (rst)
        height_in.valid |-> (height_in.col == holes_in.col));

    // result held steady until the consumer takes it
    assert property (@(posedge clk) disable iff (rst)
        (extract_ready && !ofm_done) |=> extract_ready && $stable(features));

endmodule

/* hdl/tetris_feature_extract.sv */
`include "tetris_defines.svh"

module tetris_feature_extract (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          extract_start,
    input  tetris_feature_pkg::grid_t     tetris_grid,
    input  logic                          ofm_done,
    output logic                          extract_ready,
    output tetris_feature_pkg::features_t features
);
    import tetris_feature_pkg::*;

    grid_t              cleared_grid;
    logic [`FEAT_W-1:0] lines_cleared;
    logic               clear_done;
    col_height_t        col_height;
    col_holes_t         col_holes;

    ////////////////////////////////////////
    // phase 1, full row removal
    ////////////////////////////////////////

    // a held result blocks the next start
    line_clear_unit u_line_clear (
        .clk           (clk),
        .rst           (rst),
        .extract_start (extract_start),
        .tetris_grid   (tetris_grid),
        .hold          (extract_ready),
        .cleared_grid  (cleared_grid),
        .lines_cleared (lines_cleared),
        .clear_done    (clear_done)
    );

    ////////////////////////////////////////
    // phase 2, column scans
    ////////////////////////////////////////

    column_height_scan u_height_scan (
        .clk          (clk),
        .rst          (rst),
        .clear_done   (clear_done),
        .cleared_grid (cleared_grid),
        .height_out   (col_height)
    );

    column_hole_scan u_hole_scan (
        .clk          (clk),
        .rst          (rst),
        .clear_done   (clear_done),
        .cleared_grid (cleared_grid),
        .holes_out    (col_holes)
    );

    feature_combine u_combine (
        .clk           (clk),
        .rst           (rst),
        .height_in     (col_height),
        .holes_in      (col_holes),
        .lines_cleared (lines_cleared),
        .ofm_done      (ofm_done),
        .extract_ready (extract_ready),
        .features      (features)
    );

endmodule

/* test/tb_feature_extract.sv */
`include "tetris_defines.svh"

module tb_feature_extract;
    timeunit 1ns;
    timeprecision 100ps;

    import tetris_feature_pkg::*;

    localparam int READY_TIMEOUT = 200;
    localparam int NUM_RANDOM    = 200;
    localparam int QUIET_CYCLES  = `GRID_ROWS + `GRID_COLS + 8;

    logic      clk;
    logic      rst;
    logic      extract_start;
    grid_t     tetris_grid;
    logic      ofm_done;
    logic      extract_ready;
    features_t features;

    integer    seed;
    int        check_count;
    int        mismatch_count;
    int        timeout_count;
    int        error_count;
    features_t exp_q[$];
    features_t held_features;
    logic      holding;

    tetris_feature_extract dut (
        .clk           (clk),
        .rst           (rst),
        .extract_start (extract_start),
        .tetris_grid   (tetris_grid),
        .ofm_done      (ofm_done),
        .extract_ready (extract_ready),
        .features      (features)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic features_t ref_features(input grid_t grid);
        grid_t     cleared;
        features_t f;
        int        wr;
        int        lines;
        int        hsum;
        int        bump;
        int        holes;
        int        filled;
        int        h[`GRID_COLS];
        cleared = '0;
        lines   = 0;
        wr      = `GRID_ROWS - 1;
        for (int r = `GRID_ROWS - 1; r >= 0; r--) begin
            if (&grid[r]) begin
                lines++;
            end else begin
                cleared[wr] = grid[r];
                wr--;
            end
        end
        hsum  = 0;
        bump  = 0;
        holes = 0;
        for (int c = 0; c < `GRID_COLS; c++) begin
            h[c]   = 0;
            filled = 0;
            for (int r = 0; r < `GRID_ROWS; r++) begin
                if (cleared[r][c]) begin
                    filled++;
                    if (h[c] == 0) begin
                        h[c] = `GRID_ROWS - r;
                    end
                end
            end
            // cells from the top block down are either filled or holes
            holes += h[c] - filled;
            hsum  += h[c];
            if (c > 0) begin
                bump += (h[c] > h[c-1]) ? (h[c] - h[c-1]) : (h[c-1] - h[c]);
            end
        end
        f.lines_cleared = `FEAT_W'(lines);
        f.height_sum    = `FEAT_W'(hsum);
        f.bumpiness     = `FEAT_W'(bump);
        f.holes         = `FEAT_W'(holes);
        return f;
    endfunction

    // empty above a random top row, dense or full below it
    function automatic grid_t random_grid();
        grid_t       g;
        logic [31:0] rnd;
        int          top;
        g   = '0;
        rnd = $random(seed);
        top = 4 + int'(rnd[3:0]);
        for (int r = 0; r < `GRID_ROWS; r++) begin
            rnd = $random(seed);
            if (r >= top) begin
                g[r] = (rnd[1:0] == 2'b00) ? {`GRID_COLS{1'b1}} : (rnd[11:2] | rnd[21:12]);
            end
        end
        return g;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s expected=%h actual=%h at %0t", name, expected, actual, $time);
        end
    endtask

    ////////////////////////////////////////
    // compare process
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            holding <= 1'b0;
        end else if (extract_ready && !holding) begin
            holding <= 1'b1;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("extract_ready rose with no board in flight at %0t", $time);
            end else begin
                held_features <= exp_q[0];
                check_value("lines_cleared", 32'(exp_q[0].lines_cleared),
                            32'(features.lines_cleared));
                check_value("height_sum", 32'(exp_q[0].height_sum), 32'(features.height_sum));
                check_value("bumpiness", 32'(exp_q[0].bumpiness), 32'(features.bumpiness));
                check_value("holes", 32'(exp_q[0].holes), 32'(features.holes));
                void'(exp_q.pop_front());
            end
        end else if (extract_ready) begin
            // result must not move while it is held
            check_value("features", 32'(held_features), 32'(features));
        end else begin
            holding <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic wait_ready_level(input logic level, input string what);
        int n;
        n = 0;
        while (extract_ready !== level && n < READY_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (extract_ready !== level) begin
            timeout_count++;
            $display("timeout: extract_ready did not go %0d while waiting %s", level, what);
        end
    endtask

    task automatic run_board(input grid_t grid, input int delay, input logic poke);
        logic spurious;
        if (timeout_count != 0) begin
            return;
        end
        exp_q.push_back(ref_features(grid));
        tetris_grid   <= grid;
        extract_start <= 1'b1;
        @(posedge clk);
        extract_start <= 1'b0;
        wait_ready_level(1'b1, "for the result");
        // consumer stalls, a stray start here must be ignored
        for (int n = 0; n < delay; n++) begin
            if (poke && n == delay / 2) begin
                tetris_grid   <= random_grid();
                extract_start <= 1'b1;
            end else begin
                extract_start <= 1'b0;
            end
            @(posedge clk);
        end
        extract_start <= 1'b0;
        ofm_done      <= 1'b1;
        @(posedge clk);
        ofm_done <= 1'b0;
        wait_ready_level(1'b0, "for the release after ofm_done");
        if (poke) begin
            spurious = 1'b0;
            for (int n = 0; n < QUIET_CYCLES; n++) begin
                @(posedge clk);
                spurious = spurious | extract_ready;
            end
            check_value("extract_ready", 32'd0, 32'(spurious));
        end
    endtask

    task automatic finish_run();
        $display("checks=%0d mismatches=%0d timeouts=%0d other errors=%0d",
                 check_count, mismatch_count, timeout_count, error_count);
        if (mismatch_count == 0 && timeout_count == 0 && error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin : stimulus
        grid_t       g;
        logic [31:0] rnd;
        seed           = 32'h6796_efd0;
        check_count    = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        error_count    = 0;
        rst            = 1'b1;
        extract_start  = 1'b0;
        tetris_grid    = '0;
        ofm_done       = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // empty board
        run_board('0, 2, 1'b0);

        // full bottom rows, one to four, some split apart
        g      = '0;
        g[19]  = 10'h3ff;
        run_board(g, 1, 1'b0);
        g[18]  = 10'h3ff;
        g[17]  = 10'h00f;
        run_board(g, 0, 1'b0);
        g      = '0;
        g[19]  = 10'h3ff;
        g[18]  = 10'h201;
        g[17]  = 10'h3ff;
        g[16]  = 10'h0f0;
        g[15]  = 10'h3ff;
        g[14]  = 10'h010;
        run_board(g, 3, 1'b0);
        g      = '0;
        g[19]  = 10'h3ff;
        g[18]  = 10'h3ff;
        g[17]  = 10'h3ff;
        g[16]  = 10'h3ff;
        g[15]  = 10'h155;
        run_board(g, 0, 1'b0);

        // overhang and stacked gaps
        g      = '0;
        g[15]  = 10'b00000_11100;
        g[19]  = 10'b00000_00100;
        g[8]   = 10'b10000_00000;
        for (int r = 1; r < `GRID_ROWS; r += 2) begin
            g[r][0] = 1'b1;
        end
        run_board(g, 2, 1'b0);

        // rising and zigzag staircases
        for (int r = 0; r < `GRID_ROWS; r++) begin
            for (int c = 0; c < `GRID_COLS; c++) begin
                g[r][c] = (`GRID_ROWS - r) <= 2 * c;
            end
        end
        run_board(g, 1, 1'b0);
        for (int r = 0; r < `GRID_ROWS; r++) begin
            for (int c = 0; c < `GRID_COLS; c++) begin
                g[r][c] = (`GRID_ROWS - r) <= ((c % 2 == 1) ? 15 : 3);
            end
        end
        run_board(g, 1, 1'b0);

        // long stall with a stray start
        run_board(random_grid(), 12, 1'b1);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            run_board(random_grid(), int'(rnd[3:0]), (i % 10 == 9) && (rnd[3:0] != 4'd0));
        end

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d boards never produced a result", exp_q.size());
        end
        finish_run();
    end

endmodule

/* build.f */
+incdir+include
hdl/tetris_feature_pkg.sv
hdl/line_clear_unit.sv
hdl/column_height_scan.sv
hdl/column_hole_scan.sv
hdl/feature_combine.sv
hdl/tetris_feature_extract.sv
test/tb_feature_extract.sv

/* Makefile */
# Verilator build and run for the Tetris feature extractor testbench

VERILATOR ?= verilator
TOP       ?= tb_feature_extract
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= === PASS ===

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard hdl/*.sv) $(wildcard include/*.svh) $(wildcard test/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
